// File: rtl/pwo_params_pkg.sv
// Arithmetic and memory geometry of the pointwise engine, ML-DSA prime only
// Stored coefficients are assumed already reduced below PWO_Q
`default_nettype none

package pwo_params_pkg;

    // ========================================
    // Modular arithmetic
    // ========================================

    // Q = 2^23 - 2^13 + 1, the folding reduction depends on this shape
    localparam logic [22:0] PWO_Q = 23'd8380417;

    // ========================================
    // Memory geometry
    // ========================================

    localparam int PWO_COEF_W     = 24;
    localparam int PWO_LANES      = 4;
    localparam int PWO_WORD_W     = PWO_COEF_W * PWO_LANES;
    localparam int PWO_ADDR_W     = 8;
    // N = 256 coefficients over 4 lanes
    localparam int PWO_PASS_WORDS = 64;

endpackage

`default_nettype wire

// File: rtl/pwo_types_pkg.sv
// Shared types for the pointwise engine ports
// Mode encoding 2'b11 is not named and behaves as pointwise multiply
`default_nettype none

package pwo_types_pkg;
    import pwo_params_pkg::*;

    // ========================================
    // Operation select
    // ========================================

    typedef enum logic [1:0] {
        pwm = 2'b00,
        pwa = 2'b01,
        pws = 2'b10
    } pwo_mode_t;

    // ========================================
    // Memory port request
    // ========================================

    // Read or write strobe with its word address
    typedef struct packed {
        logic                  en;
        logic [PWO_ADDR_W-1:0] addr;
    } mem_req_t;

    // ========================================
    // Coefficient word
    // ========================================

    // Lane 0 occupies the low bits of the word
    typedef struct packed {
        logic [PWO_COEF_W-1:0] lane3;
        logic [PWO_COEF_W-1:0] lane2;
        logic [PWO_COEF_W-1:0] lane1;
        logic [PWO_COEF_W-1:0] lane0;
    } coef_word_t;

endpackage

`default_nettype wire

// File: rtl/pwo_addr_seq.sv
// Pass sequencer, one A/B read pair per cycle then a fixed drain before done
// DRAIN_CYCLES must track the RAM read latency plus the lane ALU latency
`timescale 1ns/1ps
`default_nettype none

module pwo_addr_seq
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;
#(
    parameter int ADDR_W     = PWO_ADDR_W,
    parameter int PASS_WORDS = PWO_PASS_WORDS
)
(
    input  wire              clk,
    input  wire              reset_n,
    input  wire              zeroize,
    input  wire              start,
    input  wire [ADDR_W-1:0] a_base,
    input  wire [ADDR_W-1:0] b_base,

    output mem_req_t         a_rd_req,
    output mem_req_t         b_rd_req,
    output logic             busy,
    output logic             done
);

    // One cycle of RAM read plus three ALU stages
    localparam int DRAIN_CYCLES = 4;
    localparam int CNT_W        = $clog2(PASS_WORDS + DRAIN_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PASS_WORDS + DRAIN_CYCLES - 1);
    localparam logic [CNT_W-1:0] READ_CNT = CNT_W'(PASS_WORDS);

    logic [CNT_W-1:0]  cnt;
    logic              issuing;
    logic [ADDR_W-1:0] offset;
    logic [ADDR_W-1:0] a_addr;
    logic [ADDR_W-1:0] b_addr;

    // ========================================
    // Pass control
    // ========================================

    // Counter runs from 0 through the read phase and on through the drain
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end
        else if (zeroize) begin
            // Abort without a done pulse
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end
        else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    cnt  <= '0;
                end
            end
            else if (cnt == LAST_CNT) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Read requests
    // ========================================

    assign issuing = busy && (cnt < READ_CNT);
    assign offset  = ADDR_W'(cnt);

    // Both operands step together, wrapping inside the address space
    assign a_addr = a_base + offset;
    assign b_addr = b_base + offset;

    always_comb begin
        a_rd_req.en   = issuing;
        a_rd_req.addr = PWO_ADDR_W'(a_addr);
        b_rd_req.en   = issuing;
        b_rd_req.addr = PWO_ADDR_W'(b_addr);
    end

endmodule

`default_nettype wire

// File: rtl/pwo_coef_ram.sv
// Register-array word store, one write port and one registered read port
// Only the low ADDR_W bits of a request address are decoded
`timescale 1ns/1ps
`default_nettype none

module pwo_coef_ram
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;
#(
    parameter int ADDR_W = PWO_ADDR_W
)
(
    input  wire        clk,
    input  wire        reset_n,
    input  wire        zeroize,

    input  mem_req_t   wr_req,
    input  coef_word_t wr_data,
    input  mem_req_t   rd_req,
    output coef_word_t rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [PWO_WORD_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]     wr_addr;
    logic [ADDR_W-1:0]     rd_addr;

    assign wr_addr = wr_req.addr[ADDR_W-1:0];
    assign rd_addr = rd_req.addr[ADDR_W-1:0];

    // ========================================
    // Storage
    // ========================================

    // Zeroize wipes the whole array in a single cycle
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end
        else if (wr_req.en) begin
            mem[wr_addr] <= PWO_WORD_W'(wr_data);
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Data appears one cycle after the enabled read and holds until the next one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end
        else if (zeroize) begin
            rd_data <= '0;
        end
        else if (rd_req.en) begin
            rd_data <= coef_word_t'(mem[rd_addr]);
        end
    end

endmodule

`default_nettype wire

// File: rtl/pwo_lane_alu.sv
// Four-lane modular multiply/add/subtract, fixed 3-cycle latency, no stall
// Operands must already be below Q, mode and c_base are taken with the first word
`timescale 1ns/1ps
`default_nettype none

module pwo_lane_alu
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize,

    input  pwo_mode_t            mode,
    input  wire [PWO_ADDR_W-1:0] c_base,
    input  wire                  rd_valid,
    input  coef_word_t           a_data,
    input  coef_word_t           b_data,

    output mem_req_t             c_wr_req,
    output coef_word_t           c_wr_data
);

    localparam int RED_W      = $bits(PWO_Q);
    localparam int PROD_W     = 2 * RED_W;
    // 2^23 = 2^13 - 1 (mod Q), so each fold shifts the high part by 13
    localparam int FOLD_SH    = $clog2((2 ** RED_W) - int'(PWO_Q) + 1);
    // Four folds take a full product below 2Q
    localparam int FOLD_STEPS = 4;

    typedef logic [PWO_LANES-1:0][PWO_COEF_W-1:0] lane_vec_t;

    lane_vec_t                          a_lanes;
    lane_vec_t                          b_lanes;
    lane_vec_t                          c_lanes;
    logic                               rd_valid_q;
    logic                               first_word;
    pwo_mode_t                          mode_q;
    pwo_mode_t                          mode_sel;
    logic [PWO_ADDR_W-1:0]              c_base_q;
    logic [PWO_ADDR_W-1:0]              wr_cnt;
    logic                               s1_valid, s2_valid, s3_valid;
    logic [PWO_LANES-1:0][PROD_W-1:0]   s1_d, s1_val;
    logic [PWO_LANES-1:0][RED_W:0]      s2_d, s2_val;
    logic [PWO_LANES-1:0][RED_W-1:0]    s3_d, s3_val;
    logic [RED_W-1:0]                   op_a, op_b;
    logic [PROD_W-1:0]                  fold_tmp;

    // x - hi*Q written as lo + hi*2^13 - hi, never negative
    function automatic logic [PROD_W-1:0] fold_q(input logic [PROD_W-1:0] x);
        logic [PROD_W-1:0] hi;
        hi = x >> RED_W;
        return PROD_W'(x[RED_W-1:0]) + (hi << FOLD_SH) - hi;
    endfunction

    assign a_lanes = a_data;
    assign b_lanes = b_data;

    // ========================================
    // Pass capture
    // ========================================

    assign first_word = rd_valid && !rd_valid_q;
    assign mode_sel   = first_word ? mode : mode_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_q <= 1'b0;
            mode_q     <= pwm;
            c_base_q   <= '0;
            wr_cnt     <= '0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            s3_valid   <= 1'b0;
        end
        else if (zeroize) begin
            rd_valid_q <= 1'b0;
            wr_cnt     <= '0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            s3_valid   <= 1'b0;
        end
        else begin
            rd_valid_q <= rd_valid;
            s1_valid   <= rd_valid;
            s2_valid   <= s1_valid;
            s3_valid   <= s2_valid;
            if (first_word) begin
                mode_q   <= mode;
                c_base_q <= c_base;
                wr_cnt   <= '0;
            end
            else if (s3_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Stage 1, product or sum/difference
    // ========================================

    always_comb begin
        for (int i = 0; i < PWO_LANES; i++) begin
            op_a = a_lanes[i][RED_W-1:0];
            op_b = b_lanes[i][RED_W-1:0];
            case (mode_sel)
                pwa:     s1_d[i] = PROD_W'(op_a) + PROD_W'(op_b);
                // Borrow is repaired here so later stages only see positives
                pws:     s1_d[i] = (op_a >= op_b) ? PROD_W'(op_a) - PROD_W'(op_b)
                                                  : PROD_W'(op_a) + PROD_W'(PWO_Q)
                                                    - PROD_W'(op_b);
                default: s1_d[i] = PROD_W'(op_a) * PROD_W'(op_b);
            endcase
        end
    end

    // ========================================
    // Stage 2, fold high bits, then stage 3
    // ========================================

    // Sums and differences pass through the folds unharmed
    always_comb begin
        for (int i = 0; i < PWO_LANES; i++) begin
            fold_tmp = s1_val[i];
            for (int f = 0; f < FOLD_STEPS; f++) begin
                fold_tmp = fold_q(fold_tmp);
            end
            s2_d[i] = fold_tmp[RED_W:0];
        end
    end

    // Input is below 2Q, one conditional subtract finishes it
    always_comb begin
        for (int i = 0; i < PWO_LANES; i++) begin
            if (s2_val[i] >= (RED_W + 1)'(PWO_Q)) begin
                s3_d[i] = RED_W'(s2_val[i] - (RED_W + 1)'(PWO_Q));
            end
            else begin
                s3_d[i] = s2_val[i][RED_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_val <= s1_d;
        s2_val <= s2_d;
        s3_val <= s3_d;
    end

    // ========================================
    // C write port
    // ========================================

    always_comb begin
        for (int i = 0; i < PWO_LANES; i++) begin
            c_lanes[i] = PWO_COEF_W'(s3_val[i]);
        end
    end

    assign c_wr_data     = coef_word_t'(c_lanes);
    assign c_wr_req.en   = s3_valid;
    assign c_wr_req.addr = c_base_q + wr_cnt;

endmodule

`default_nettype wire

// File: rtl/pwo_top.sv
// Pointwise engine top, A/B/C memories with host access only while idle
// Host loads and reads issued while busy are silently dropped
`timescale 1ns/1ps
`default_nettype none

module pwo_top
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;
#(
    parameter int ADDR_W     = PWO_ADDR_W,
    parameter int PASS_WORDS = PWO_PASS_WORDS
)
(
    input  wire              clk,
    input  wire              reset_n,
    input  wire              zeroize,

    input  wire              start,
    input  pwo_mode_t        mode,
    input  wire [ADDR_W-1:0] a_base,
    input  wire [ADDR_W-1:0] b_base,
    input  wire [ADDR_W-1:0] c_base,

    input  wire              load_en,
    input  wire              load_sel,
    input  wire [ADDR_W-1:0] load_addr,
    input  coef_word_t       load_data,

    input  wire              host_rd_en,
    input  wire [ADDR_W-1:0] host_rd_addr,
    output coef_word_t       host_rd_data,
    output logic             host_rd_valid,

    output logic             busy,
    output logic             done
);

    // Engine side
    mem_req_t              seq_a_req, seq_b_req;
    mem_req_t              alu_c_req;
    coef_word_t            alu_c_data;
    logic [PWO_ADDR_W-1:0] alu_c_base;
    logic                  a_rd_valid, b_rd_valid;

    // Muxed RAM ports
    mem_req_t              ram_a_wr_req, ram_b_wr_req, ram_c_wr_req;
    mem_req_t              ram_a_rd_req, ram_b_rd_req, ram_c_rd_req;
    coef_word_t            a_rd_data, b_rd_data, c_rd_data;

    assign alu_c_base = PWO_ADDR_W'(c_base);

    // ========================================
    // Port muxes, engine owns the RAMs while busy
    // ========================================

    always_comb begin
        ram_a_wr_req.en   = load_en && !busy && !load_sel;
        ram_a_wr_req.addr = PWO_ADDR_W'(load_addr);
        ram_b_wr_req.en   = load_en && !busy && load_sel;
        ram_b_wr_req.addr = PWO_ADDR_W'(load_addr);
        ram_c_rd_req.en   = host_rd_en && !busy;
        ram_c_rd_req.addr = PWO_ADDR_W'(host_rd_addr);
        if (busy) begin
            ram_a_rd_req = seq_a_req;
            ram_b_rd_req = seq_b_req;
            ram_c_wr_req = alu_c_req;
        end
        else begin
            ram_a_rd_req = '0;
            ram_b_rd_req = '0;
            ram_c_wr_req = '0;
        end
    end

    // Read valids follow the enables by one cycle, matching RAM latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_rd_valid    <= 1'b0;
            b_rd_valid    <= 1'b0;
            host_rd_valid <= 1'b0;
        end
        else begin
            a_rd_valid    <= ram_a_rd_req.en && !zeroize;
            b_rd_valid    <= ram_b_rd_req.en && !zeroize;
            host_rd_valid <= ram_c_rd_req.en;
        end
    end

    assign host_rd_data = c_rd_data;

    // ========================================
    // Sequencer, memories and datapath
    // ========================================

    pwo_addr_seq #(
        .ADDR_W     (ADDR_W),
        .PASS_WORDS (PASS_WORDS)
    ) i_addr_seq (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .start    (start),
        .a_base   (a_base),
        .b_base   (b_base),
        .a_rd_req (seq_a_req),
        .b_rd_req (seq_b_req),
        .busy     (busy),
        .done     (done)
    );

    pwo_coef_ram #(.ADDR_W(ADDR_W)) ram_a (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .wr_req  (ram_a_wr_req),
        .wr_data (load_data),
        .rd_req  (ram_a_rd_req),
        .rd_data (a_rd_data)
    );

    pwo_coef_ram #(.ADDR_W(ADDR_W)) ram_b (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .wr_req  (ram_b_wr_req),
        .wr_data (load_data),
        .rd_req  (ram_b_rd_req),
        .rd_data (b_rd_data)
    );

    pwo_coef_ram #(.ADDR_W(ADDR_W)) ram_c (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .wr_req  (ram_c_wr_req),
        .wr_data (alu_c_data),
        .rd_req  (ram_c_rd_req),
        .rd_data (c_rd_data)
    );

    pwo_lane_alu i_lane_alu (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .mode      (mode),
        .c_base    (alu_c_base),
        .rd_valid  (a_rd_valid && b_rd_valid),
        .a_data    (a_rd_data),
        .b_data    (b_rd_data),
        .c_wr_req  (alu_c_req),
        .c_wr_data (alu_c_data)
    );

endmodule

`default_nettype wire

// File: verif/pwo_tb.sv
// Self-checking testbench for the pointwise engine at the default geometry of 64 words per pass
// Operands are drawn below Q, and C is undefined until the first pass or zeroize
`timescale 1ns/1ps
`default_nettype none

module pwo_tb
    import pwo_params_pkg::*;
    import pwo_types_pkg::*;
;

    localparam int PASS_CYCLES  = 69;
    localparam int PASS_SLACK   = 16;
    localparam int N_PASSES     = 5;
    localparam int RESET_CYCLES = 10;
    localparam int LOAD_WORDS   = 70;
    localparam int N_READS      = 4 * PWO_PASS_WORDS + 4 + 256 + 1;
    localparam int TEST_CYCLES  = RESET_CYCLES + LOAD_WORDS * 2
                                + N_PASSES * (PASS_CYCLES + PASS_SLACK) + N_READS * 2;
    // 20 percent margin on top of the sum of all tests
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 12 / 10;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  zeroize;
    logic                  start;
    pwo_mode_t             mode;
    logic [PWO_ADDR_W-1:0] a_base, b_base, c_base;
    logic                  load_en;
    logic                  load_sel;
    logic [PWO_ADDR_W-1:0] load_addr;
    coef_word_t            load_data;
    logic                  host_rd_en;
    logic [PWO_ADDR_W-1:0] host_rd_addr;
    coef_word_t            host_rd_data;
    logic                  host_rd_valid;
    logic                  busy;
    logic                  done;

    integer     seed = 20252;
    coef_word_t a_ref [256];
    coef_word_t b_ref [256];

    always #10 clk = ~clk;

    pwo_top i_pwo_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .start         (start),
        .mode          (mode),
        .a_base        (a_base),
        .b_base        (b_base),
        .c_base        (c_base),
        .load_en       (load_en),
        .load_sel      (load_sel),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .host_rd_en    (host_rd_en),
        .host_rd_addr  (host_rd_addr),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid),
        .busy          (busy),
        .done          (done)
    );

    // ========================================
    // Failure reporting and reference model
    // ========================================

    task automatic report_mismatch(input string test, input logic [95:0] exp,
                                   input logic [95:0] act);
        $display("Fail %s: expected %0h, actual %0h", test, exp, act);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic logic [PWO_COEF_W-1:0] model_lane(input pwo_mode_t m,
                                                         input logic [PWO_COEF_W-1:0] a,
                                                         input logic [PWO_COEF_W-1:0] b);
        longint unsigned x, y, q;
        x = a;
        y = b;
        q = PWO_Q;
        case (m)
            pwa:     return PWO_COEF_W'((x + y) % q);
            pws:     return PWO_COEF_W'((x + q - y) % q);
            default: return PWO_COEF_W'((x * y) % q);
        endcase
    endfunction

    function automatic coef_word_t model_word(input pwo_mode_t m, input coef_word_t a,
                                              input coef_word_t b);
        logic [PWO_LANES-1:0][PWO_COEF_W-1:0] av, bv, rv;
        av = a;
        bv = b;
        for (int i = 0; i < PWO_LANES; i++) begin
            rv[i] = model_lane(m, av[i], bv[i]);
        end
        return coef_word_t'(rv);
    endfunction

    function automatic coef_word_t random_word();
        logic [PWO_LANES-1:0][PWO_COEF_W-1:0] w;
        logic [31:0] r;
        for (int i = 0; i < PWO_LANES; i++) begin
            r    = $random(seed);
            w[i] = PWO_COEF_W'(r % PWO_Q);
        end
        return coef_word_t'(w);
    endfunction

    // ========================================
    // Protocol checks
    // ========================================

    assert property (@(posedge clk) disable iff (!reset_n) done |-> (!busy && $past(busy)))
        else report_error("done pulsed without busy falling on the same edge");
    assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
        else report_error("done stayed high for more than one cycle");
    // Reads issued while busy are dropped
    assert property (@(posedge clk) disable iff (!reset_n)
                     host_rd_valid == $past(host_rd_en && !busy))
        else report_error("host_rd_valid did not follow an idle host read by one cycle");

    // ========================================
    // Host port and pass tasks
    // ========================================

    task automatic load_operands(input int n);
        for (int w = 0; w < n; w++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_sel  <= 1'b0;
            load_addr <= PWO_ADDR_W'(w);
            load_data <= a_ref[w];
            @(posedge clk);
            load_sel  <= 1'b1;
            load_data <= b_ref[w];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic read_c(input logic [PWO_ADDR_W-1:0] addr, input string test,
                          output coef_word_t word);
        @(posedge clk);
        host_rd_en   <= 1'b1;
        host_rd_addr <= addr;
        @(negedge clk);
        assert (!host_rd_valid) else report_mismatch({test, " early valid"}, 0, host_rd_valid);
        @(posedge clk);
        host_rd_en <= 1'b0;
        @(negedge clk);
        assert (host_rd_valid) else report_mismatch({test, " read valid"}, 1, host_rd_valid);
        word = host_rd_data;
    endtask

    // Start is re-issued mid-pass and must not disturb the 69-cycle timing
    // A host read is also issued mid-pass and must return no valid
    task automatic run_pass(input pwo_mode_t m, input logic [PWO_ADDR_W-1:0] ab,
                            input logic [PWO_ADDR_W-1:0] bb, input logic [PWO_ADDR_W-1:0] cb,
                            input string test);
        int k;
        @(posedge clk);
        start  <= 1'b1;
        mode   <= m;
        a_base <= ab;
        b_base <= bb;
        c_base <= cb;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (busy) else report_mismatch({test, " busy on edge 1"}, 1, busy);
        k = 1;
        while (!done && k < PASS_CYCLES + PASS_SLACK) begin
            @(posedge clk);
            start      <= (k == 4);
            host_rd_en <= (k == 6);
            @(negedge clk);
            k++;
            if (!done) begin
                assert (busy) else report_mismatch({test, " busy during pass"}, 1, busy);
            end
        end
        assert (k == PASS_CYCLES) else report_mismatch({test, " start to done"}, PASS_CYCLES, k);
        @(negedge clk);
        assert (!busy) else report_mismatch({test, " busy after done"}, 0, busy);
    endtask

    task automatic check_pass(input pwo_mode_t m, input logic [PWO_ADDR_W-1:0] ab,
                              input logic [PWO_ADDR_W-1:0] bb, input logic [PWO_ADDR_W-1:0] cb,
                              input string test);
        coef_word_t got, exp;
        for (int k = 0; k < PWO_PASS_WORDS; k++) begin
            read_c(cb + PWO_ADDR_W'(k), test, got);
            exp = model_word(m, a_ref[ab + k], b_ref[bb + k]);
            assert (got === exp) else report_mismatch(test, exp, got);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        coef_word_t got;
        coef_word_t sent_lo;
        coef_word_t sent_hi;
        logic [PWO_COEF_W-1:0] qm1;
        qm1 = PWO_COEF_W'(PWO_Q) - 1'b1;
        reset_n      <= 1'b0;
        zeroize      <= 1'b0;
        start        <= 1'b0;
        mode         <= pwm;
        a_base       <= '0;
        b_base       <= '0;
        c_base       <= '0;
        load_en      <= 1'b0;
        load_sel     <= 1'b0;
        load_addr    <= '0;
        load_data    <= '0;
        host_rd_en   <= 1'b0;
        host_rd_addr <= '0;
        for (int w = 0; w < LOAD_WORDS; w++) begin
            a_ref[w] = random_word();
            b_ref[w] = random_word();
        end
        // Q-1 operands and forced borrows in the first two words
        a_ref[0] = {qm1, qm1, qm1, qm1};
        b_ref[0] = {qm1, 24'd1, 24'd0, qm1};
        a_ref[1] = {24'd0, 24'd1, 24'd5, qm1};
        b_ref[1] = {qm1, 24'd2, 24'd5, 24'd0};
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        assert (!busy && !done && !host_rd_valid)
            else report_mismatch("reset_idle", 0, {busy, done, host_rd_valid});
        read_c(8'd0, "reset_read", got);

        load_operands(LOAD_WORDS);
        run_pass(pwm, 8'd0, 8'd0, 8'd0, "pwm_pass");
        check_pass(pwm, 8'd0, 8'd0, 8'd0, "pwm_data");
        run_pass(pwa, 8'd0, 8'd0, 8'd0, "pwa_pass");
        check_pass(pwa, 8'd0, 8'd0, 8'd0, "pwa_data");
        run_pass(pws, 8'd0, 8'd0, 8'd0, "pws_pass");
        check_pass(pws, 8'd0, 8'd0, 8'd0, "pws_data");

        // Offset bases with the words on both sides of the C window as sentinels
        read_c(8'd0, "sentinel_lo", sent_lo);
        read_c(8'd65, "sentinel_hi", sent_hi);
        run_pass(pwm, 8'd3, 8'd5, 8'd1, "base_pass");
        check_pass(pwm, 8'd3, 8'd5, 8'd1, "base_data");
        read_c(8'd0, "sentinel_lo", got);
        assert (got === sent_lo) else report_mismatch("sentinel_lo", sent_lo, got);
        read_c(8'd65, "sentinel_hi", got);
        assert (got === sent_hi) else report_mismatch("sentinel_hi", sent_hi, got);

        // Zeroize in the middle of a pass must suppress done
        @(posedge clk);
        start <= 1'b1;
        mode  <= pwa;
        @(posedge clk);
        start <= 1'b0;
        repeat (20) @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (60) begin
            @(negedge clk);
            assert (!busy && !done)
                else report_mismatch("zeroize_abort", 0, {busy, done});
        end
        for (int a = 0; a < 256; a++) begin
            read_c(PWO_ADDR_W'(a), "zeroize_data", got);
            assert (got === '0) else report_mismatch("zeroize_data", 0, got);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: the run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/pwo_params_pkg.sv
rtl/pwo_types_pkg.sv
rtl/pwo_addr_seq.sv
rtl/pwo_coef_ram.sv
rtl/pwo_lane_alu.sv
rtl/pwo_top.sv
verif/pwo_tb.sv
